/* common/thermo_defs.svh */
`ifndef THERMO_DEFS_SVH
`define THERMO_DEFS_SVH

// ==============================
// Serial timing
// ==============================

// clk_50 cycles per SCLK bit period with SCLK low in the first half
`define THERMO_SCLK_DIV 10

// Bits shifted out by the MAX31855 in one conversion frame
`define THERMO_FRAME_BITS 32

// ==============================
// Acquisition pacing
// ==============================

// Idle clk_50 cycles between the end of a host handshake and the next read
`define THERMO_SAMPLE_GAP 200

`endif

/* common/thermo_frame_pkg.sv */
package thermo_frame_pkg;

    // ==============================
    // MAX31855 serial frame
    // ==============================

    // Field order follows the wire order with the first bit out at the top
    typedef struct packed {
        logic signed [13:0] tc_temp;    // Thermocouple temperature in 0.25 C steps
        logic               rsvd_hi;    // Always reads as 0
        logic               fault;      // Set when any of the three flags below is set
        logic signed [11:0] cj_temp;    // Cold junction temperature in 0.0625 C steps
        logic               rsvd_lo;    // Always reads as 0
        logic               scv;        // Thermocouple shorted to VCC
        logic               scg;        // Thermocouple shorted to GND
        logic               oc;         // Thermocouple open circuit
    } max31855_frame_t;

endpackage

/* common/thermo_result_pkg.sv */
package thermo_result_pkg;

    // ==============================
    // Decoded measurement
    // ==============================

    typedef struct packed {
        logic signed [13:0] tc_temp;
        logic signed [11:0] cj_temp;
        logic               scv;
        logic               scg;
        logic               oc;
        logic               frame_error;    // Frame failed its own consistency check
    } thermo_result_t;

endpackage

/* common/spi_frame_if.sv */
interface spi_frame_if;
    import thermo_frame_pkg::*;

    logic            start;          // One cycle request to read a frame
    logic            busy;           // Reader is between start and frame_valid
    logic            frame_valid;    // One cycle strobe when frame is fresh
    max31855_frame_t frame;          // Held until the next start

    modport reader (
        input  start,
        output busy,
        output frame_valid,
        output frame
    );

    modport decoder (
        input  frame_valid,
        input  frame
    );

endinterface

/* max31855/max31855_spi_reader.sv */
`include "thermo_defs.svh"

module max31855_spi_reader (
    input  logic        clk_50,
    input  logic        reset,
    spi_frame_if.reader bus,
    output logic        max_sclk,
    output logic        max_csn,
    input  logic        max_sdo
);
    import thermo_frame_pkg::*;

    localparam int SCLK_DIV   = `THERMO_SCLK_DIV;
    localparam int HALF_DIV   = SCLK_DIV / 2;
    localparam int FRAME_BITS = `THERMO_FRAME_BITS;
    localparam int DIV_W      = $clog2(SCLK_DIV);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_TRAIL,
        ST_DONE
    } state_t;

    state_t                state;
    logic [DIV_W-1:0]      div_cnt;
    logic [BIT_W-1:0]      bit_cnt;
    logic [FRAME_BITS-1:0] shift_reg;
    logic                  half_end;
    logic                  period_end;

    assign half_end   = (div_cnt == DIV_W'(HALF_DIV - 1));
    assign period_end = (div_cnt == DIV_W'(SCLK_DIV - 1));
    assign bus.busy   = (state != ST_IDLE);

    // ==============================
    // Bit timing
    // ==============================

    always_ff @(posedge clk_50) begin
        if (reset) begin
            div_cnt <= '0;
        end else if (state == ST_READ || state == ST_TRAIL) begin
            if (period_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end else begin
            div_cnt <= '0;
        end
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            max_sclk <= 1'b0;
        end else if (state == ST_READ) begin
            if (half_end || period_end) begin
                max_sclk <= ~max_sclk;     // Rises mid period and falls at its end
            end
        end else begin
            max_sclk <= 1'b0;              // No clock pulse in the trailing period
        end
    end

    // ==============================
    // Frame FSM
    // ==============================

    always_ff @(posedge clk_50) begin
        if (reset) begin
            state           <= ST_IDLE;
            bit_cnt         <= '0;
            max_csn         <= 1'b1;
            bus.frame_valid <= 1'b0;
        end else begin
            bus.frame_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (bus.start) begin
                        max_csn <= 1'b0;   // Sensor puts its first bit on SDO here
                        bit_cnt <= '0;
                        state   <= ST_READ;
                    end
                end
                ST_READ: begin
                    if (period_end) begin
                        if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                            state <= ST_TRAIL;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                ST_TRAIL: begin
                    if (period_end) begin
                        max_csn <= 1'b1;
                        state   <= ST_DONE;
                    end
                end
                default: begin
                    bus.frame_valid <= 1'b1;
                    state           <= ST_IDLE;
                end
            endcase
        end
    end

    // Sample SDO on the last cycle of each bit period while SCLK is high
    always_ff @(posedge clk_50) begin
        if (state == ST_READ && period_end) begin
            shift_reg <= {shift_reg[FRAME_BITS-2:0], max_sdo};
        end
        if (state == ST_TRAIL && period_end) begin
            bus.frame <= max31855_frame_t'(shift_reg);
        end
    end

    a_csn_high_when_idle: assert property (
        @(posedge clk_50) disable iff (reset) !bus.busy |-> max_csn
    );

    a_sclk_low_when_deselected: assert property (
        @(posedge clk_50) disable iff (reset) max_csn |-> !max_sclk
    );

endmodule

/* max31855/max31855_frame_decoder.sv */
module max31855_frame_decoder (
    input  logic                              clk_50,
    input  logic                              reset,
    spi_frame_if.decoder                      bus,
    output logic                              result_valid,
    output thermo_result_pkg::thermo_result_t result
);
    import thermo_frame_pkg::*;
    import thermo_result_pkg::*;

    max31855_frame_t frame;
    thermo_result_t  decoded;
    logic            any_flag;

    assign frame    = bus.frame;
    assign any_flag = frame.scv | frame.scg | frame.oc;

    // ==============================
    // Field split and check
    // ==============================

    always_comb begin
        decoded.tc_temp = frame.tc_temp;
        decoded.cj_temp = frame.cj_temp;
        decoded.scv     = frame.scv;
        decoded.scg     = frame.scg;
        decoded.oc      = frame.oc;
        // Reserved bits must read 0 and the summary bit must match the flags
        decoded.frame_error = frame.rsvd_hi | frame.rsvd_lo | (frame.fault != any_flag);
    end

    always_ff @(posedge clk_50) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= bus.frame_valid;    // Exactly one cycle behind the reader
        end
    end

    always_ff @(posedge clk_50) begin
        if (bus.frame_valid) begin
            result <= decoded;
        end
    end

    a_single_cycle_valid: assert property (
        @(posedge clk_50) disable iff (reset) result_valid |=> !result_valid
    );

endmodule

/* hdl/acq_scheduler.sv */
`include "thermo_defs.svh"

module acq_scheduler (
    input  logic                              clk_50,
    input  logic                              reset,
    input  logic                              acq_enable,
    output logic                              start,
    input  logic                              result_valid,
    input  thermo_result_pkg::thermo_result_t result_in,
    output logic                              result_req,
    input  logic                              result_ack,
    output thermo_result_pkg::thermo_result_t result_out
);
    localparam int SAMPLE_GAP = `THERMO_SAMPLE_GAP;
    localparam int GAP_W      = $clog2(SAMPLE_GAP);

    typedef enum logic [2:0] {
        ST_GAP,
        ST_START,
        ST_WAIT_RES,
        ST_REQ,
        ST_WAIT_ACK_LOW
    } state_t;

    state_t           state;
    logic [GAP_W-1:0] gap_cnt;

    assign start = (state == ST_START);

    // ==============================
    // Pacing and host handshake
    // ==============================

    always_ff @(posedge clk_50) begin
        if (reset) begin
            state      <= ST_GAP;
            gap_cnt    <= '0;
            result_req <= 1'b0;
        end else begin
            case (state)
                ST_GAP: begin
                    if (gap_cnt != GAP_W'(SAMPLE_GAP - 1)) begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end else if (acq_enable) begin
                        state <= ST_START;    // Gap is over and the host allows reads
                    end
                end
                ST_START: begin
                    state <= ST_WAIT_RES;
                end
                ST_WAIT_RES: begin
                    if (result_valid) begin
                        result_req <= 1'b1;
                        state      <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (result_ack) begin
                        result_req <= 1'b0;
                        state      <= ST_WAIT_ACK_LOW;
                    end
                end
                default: begin
                    if (!result_ack) begin
                        gap_cnt <= '0;
                        state   <= ST_GAP;
                    end
                end
            endcase
        end
    end

    // Only loaded while result_req is low so the host sees a stable value
    always_ff @(posedge clk_50) begin
        if (state == ST_WAIT_RES && result_valid) begin
            result_out <= result_in;
        end
    end

    a_req_falls_after_ack: assert property (
        @(posedge clk_50) disable iff (reset) $fell(result_req) |-> $past(result_ack)
    );

    a_result_stable_in_req: assert property (
        @(posedge clk_50) disable iff (reset)
        result_req && $past(result_req) |-> $stable(result_out)
    );

endmodule

/* hdl/thermo_acq_top.sv */
module thermo_acq_top (
    input  logic        clk_50,
    input  logic        reset,
    input  logic        acq_enable,
    output logic        max_sclk,
    output logic        max_csn,
    input  logic        max_sdo,
    output logic        result_req,
    input  logic        result_ack,
    output logic [13:0] thermo_temp,
    output logic [11:0] junction_temp,
    output logic        scv_fault,
    output logic        scg_fault,
    output logic        oc_fault,
    output logic        frame_error
);
    import thermo_result_pkg::*;

    logic           start;
    logic           result_valid;
    thermo_result_t decoded;
    thermo_result_t held;

    spi_frame_if frame_bus ();

    assign frame_bus.start = start;

    // ==============================
    // Sensor path
    // ==============================

    max31855_spi_reader reader_i (
        .clk_50   (clk_50),
        .reset    (reset),
        .bus      (frame_bus.reader),
        .max_sclk (max_sclk),
        .max_csn  (max_csn),
        .max_sdo  (max_sdo)
    );

    max31855_frame_decoder decoder_i (
        .clk_50       (clk_50),
        .reset        (reset),
        .bus          (frame_bus.decoder),
        .result_valid (result_valid),
        .result       (decoded)
    );

    acq_scheduler scheduler_i (
        .clk_50       (clk_50),
        .reset        (reset),
        .acq_enable   (acq_enable),
        .start        (start),
        .result_valid (result_valid),
        .result_in    (decoded),
        .result_req   (result_req),
        .result_ack   (result_ack),
        .result_out   (held)
    );

    // Host side sees the held result as separate fields
    assign thermo_temp   = held.tc_temp;
    assign junction_temp = held.cj_temp;
    assign scv_fault     = held.scv;
    assign scg_fault     = held.scg;
    assign oc_fault      = held.oc;
    assign frame_error   = held.frame_error;

endmodule

/* verif/max31855_model.sv */
`include "thermo_defs.svh"

module max31855_model (
    input  thermo_frame_pkg::max31855_frame_t word,
    input  logic                              max_sclk,
    input  logic                              max_csn,
    output logic                              max_sdo
);
    import thermo_frame_pkg::*;

    localparam int FRAME_BITS = `THERMO_FRAME_BITS;

    logic [FRAME_BITS-1:0] shift_word;

    initial begin
        shift_word = '0;
        max_sdo    = 1'b0;
    end

    // ==============================
    // Serial output
    // ==============================

    // Select latches the word and puts its MSB on SDO right away
    always @(negedge max_csn) begin
        shift_word = word;
        max_sdo    = shift_word[FRAME_BITS-1];
    end

    // The next bit follows every falling SCLK edge while selected
    always @(negedge max_sclk) begin
        if (!max_csn) begin
            shift_word = {shift_word[FRAME_BITS-2:0], 1'b0};
            max_sdo    = shift_word[FRAME_BITS-1];
        end
    end

    always @(posedge max_csn) begin
        max_sdo = 1'b0;    // Output idles low while deselected
    end

endmodule

/* verif/thermo_acq_tb.sv */
`include "thermo_defs.svh"

module thermo_acq_tb;
    import thermo_frame_pkg::*;

    localparam int N_RANDOM       = 8;
    localparam int N_BACKPRESSURE = 6;
    localparam int N_TESTS        = N_RANDOM + 3 + 4 + N_BACKPRESSURE;
    localparam int DISABLED_CYCLES = 300;
    localparam int MAX_HOST_DELAY = 500;
    localparam int TIMEOUT_CYCLES = 16 + DISABLED_CYCLES + N_TESTS *
        (`THERMO_SAMPLE_GAP + 33 * `THERMO_SCLK_DIV + MAX_HOST_DELAY + 50);

    logic            clk_50;
    logic            reset;
    logic            acq_enable;
    logic            max_sclk;
    logic            max_csn;
    logic            max_sdo;
    logic            result_req;
    logic            result_ack;
    logic [13:0]     thermo_temp;
    logic [11:0]     junction_temp;
    logic            scv_fault;
    logic            scg_fault;
    logic            oc_fault;
    logic            frame_error;
    max31855_frame_t loaded_word;
    logic [13:0]     exp_tc;
    logic [11:0]     exp_cj;
    logic            exp_error;
    logic [29:0]     host_fields;
    logic [31:0]     lfsr_state;
    int              error_count;
    int              errors_at_start;
    int              pass_count;
    int              fail_count;
    int              words_loaded;
    int              reads_started;
    int              cycle_count;
    max31855_frame_t word;
    int              i;

    thermo_acq_top dut_i (
        .clk_50        (clk_50),
        .reset         (reset),
        .acq_enable    (acq_enable),
        .max_sclk      (max_sclk),
        .max_csn       (max_csn),
        .max_sdo       (max_sdo),
        .result_req    (result_req),
        .result_ack    (result_ack),
        .thermo_temp   (thermo_temp),
        .junction_temp (junction_temp),
        .scv_fault     (scv_fault),
        .scg_fault     (scg_fault),
        .oc_fault      (oc_fault),
        .frame_error   (frame_error)
    );

    max31855_model sensor_i (
        .word     (loaded_word),
        .max_sclk (max_sclk),
        .max_csn  (max_csn),
        .max_sdo  (max_sdo)
    );

    always #10 clk_50 = ~clk_50;

    // Expected fields come straight from the bit layout of the loaded word
    assign exp_tc      = loaded_word[31:18];
    assign exp_cj      = loaded_word[15:4];
    assign exp_error   = loaded_word[17] | loaded_word[3] | (loaded_word[16] != |loaded_word[2:0]);
    assign host_fields = {thermo_temp, junction_temp, scv_fault, scg_fault, oc_fault, frame_error};

    // Each sensor select is one read of the loaded word
    always @(negedge max_csn) begin
        reads_started = reads_started + 1;
    end

    // ==============================
    // Helpers
    // ==============================

    function automatic logic rand_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;    // Taps 32 22 2 1
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        int          k;
        value = '0;
        for (k = 0; k < n; k++) begin
            value = {value[30:0], rand_bit()};
        end
        return value;
    endfunction

    function automatic max31855_frame_t random_valid_frame();
        max31855_frame_t frame;
        frame         = '0;
        frame.tc_temp = 14'(rand_bits(14));
        frame.cj_temp = 12'(rand_bits(12));
        return frame;
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                            input logic [31:0] actual);
        $display("MISMATCH at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
        error_count++;
    endfunction

    function automatic void report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endfunction

    task automatic end_test(input string label);
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("PASS  %s", label);
        end else begin
            fail_count++;
            $display("FAIL  %s", label);
        end
    endtask

    // One word in, one four-phase handshake out
    task automatic run_frame(input max31855_frame_t frame, input int host_delay,
                             input string label);
        errors_at_start = error_count;
        @(posedge clk_50);
        loaded_word <= frame;
        words_loaded = words_loaded + 1;
        do @(negedge clk_50); while (!result_req);
        repeat (host_delay) @(posedge clk_50);
        @(posedge clk_50);
        result_ack <= 1'b1;
        do @(negedge clk_50); while (result_req);
        @(posedge clk_50);
        result_ack <= 1'b0;
        end_test(label);
    endtask

    // ==============================
    // Checks
    // ==============================

    a_reset_state: assert property (@(posedge clk_50)
        reset |=> !result_req && max_csn && !max_sclk)
        else report_failure("Outputs not in their reset state after a reset cycle");

    a_no_read_when_disabled: assert property (@(posedge clk_50) disable iff (reset)
        $fell(max_csn) |-> $past(acq_enable, 2))
        else report_failure("Sensor was selected while acq_enable was low");

    a_tc: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_ack) |-> thermo_temp == exp_tc)
        else report_mismatch("thermo_temp", 32'(exp_tc), 32'(thermo_temp));

    a_cj: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_ack) |-> junction_temp == exp_cj)
        else report_mismatch("junction_temp", 32'(exp_cj), 32'(junction_temp));

    a_scv: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_ack) |-> scv_fault == loaded_word.scv)
        else report_mismatch("scv_fault", 32'(loaded_word.scv), 32'(scv_fault));

    a_scg: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_ack) |-> scg_fault == loaded_word.scg)
        else report_mismatch("scg_fault", 32'(loaded_word.scg), 32'(scg_fault));

    a_oc: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_ack) |-> oc_fault == loaded_word.oc)
        else report_mismatch("oc_fault", 32'(loaded_word.oc), 32'(oc_fault));

    a_frame_error: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_ack) |-> frame_error == exp_error)
        else report_mismatch("frame_error", 32'(exp_error), 32'(frame_error));

    a_stable_in_req: assert property (@(posedge clk_50) disable iff (reset)
        result_req && $past(result_req) |-> $stable(host_fields))
        else report_failure("Result outputs changed while result_req was high");

    a_csn_held: assert property (@(posedge clk_50) disable iff (reset)
        (result_req || result_ack) |-> max_csn)
        else report_failure("A new read started before the host handshake completed");

    a_one_result_per_word: assert property (@(posedge clk_50) disable iff (reset)
        $rose(result_req) |-> reads_started > 0 && reads_started == words_loaded)
        else report_failure("Result request does not match one sensor read per loaded word");

    always @(posedge clk_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles waiting for a DUT handshake", cycle_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial begin
        clk_50          = 1'b0;
        reset           = 1'b1;
        acq_enable      = 1'b0;
        result_ack      = 1'b0;
        loaded_word     = '0;
        lfsr_state      = 32'hfecb2735;
        error_count     = 0;
        errors_at_start = 0;
        pass_count      = 0;
        fail_count      = 0;
        words_loaded    = 0;
        reads_started   = 0;
        cycle_count     = 0;

        repeat (16) @(posedge clk_50);
        reset <= 1'b0;
        repeat (DISABLED_CYCLES) @(posedge clk_50);    // Gap runs out with reads held off
        end_test("reset and acq_enable low");
        acq_enable <= 1'b1;

        for (i = 0; i < N_RANDOM; i++) begin
            word = random_valid_frame();
            if (i == 0) begin
                word.tc_temp[13] = 1'b1;    // Make sure both signs are seen
                word.cj_temp[11] = 1'b1;
            end
            run_frame(word, int'(rand_bits(4)), $sformatf("valid frame %0d", i));
        end

        word       = random_valid_frame();
        word.fault = 1'b1;
        word.oc    = 1'b1;
        run_frame(word, int'(rand_bits(4)), "open circuit flag");
        word       = random_valid_frame();
        word.fault = 1'b1;
        word.scg   = 1'b1;
        run_frame(word, int'(rand_bits(4)), "short to GND flag");
        word       = random_valid_frame();
        word.fault = 1'b1;
        word.scv   = 1'b1;
        run_frame(word, int'(rand_bits(4)), "short to VCC flag");

        word         = random_valid_frame();
        word.rsvd_hi = 1'b1;
        run_frame(word, int'(rand_bits(4)), "upper reserved bit set");
        word         = random_valid_frame();
        word.rsvd_lo = 1'b1;
        run_frame(word, int'(rand_bits(4)), "lower reserved bit set");
        word       = random_valid_frame();
        word.fault = 1'b1;
        run_frame(word, int'(rand_bits(4)), "fault bit without flag");
        word     = random_valid_frame();
        word.scg = 1'b1;
        run_frame(word, int'(rand_bits(4)), "flag without fault bit");

        for (i = 0; i < N_BACKPRESSURE; i++) begin
            word = random_valid_frame();
            run_frame(word, int'(rand_bits(9)) % (MAX_HOST_DELAY + 1),
                      $sformatf("slow host %0d", i));
        end

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+common
common/thermo_frame_pkg.sv
common/thermo_result_pkg.sv
common/spi_frame_if.sv
max31855/max31855_spi_reader.sv
max31855/max31855_frame_decoder.sv
hdl/acq_scheduler.sv
hdl/thermo_acq_top.sv
verif/max31855_model.sv
verif/thermo_acq_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the thermocouple acquisition testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f sim.f --top-module thermo_acq_tb \
    && ./obj_dir/Vthermo_acq_tb | tee /dev/stderr | grep -q "Testbench passed" \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }
